/* common/gmii_rx_pkg.sv */
// gmii byte mode only; rx_stat carries end-of-frame pulses and no running counters
`default_nettype none

package gmii_rx_pkg;

    localparam int BYTE_W = 8;

    typedef enum logic [BYTE_W-1:0] {
        ETH_PRE = 8'h55,
        ETH_SFD = 8'hd5
    } eth_pre_t;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_PIPE,
        STATE_PAYLOAD
    } rx_state_t;

    // reflected ethernet polynomial, register starts at all ones
    localparam logic [31:0] CRC_POLY    = 32'hedb88320;
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              dv;
        logic              er;
    } gmii_sample_t;

    // user on the last beat marks a bad frame
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              valid;
        logic              last;
        logic              user;
    } rx_beat_t;

    // mcast is the raw group bit of the destination
    typedef struct packed {
        logic mcast;
        logic bcast;
        logic vlan;
    } hdr_flags_t;

    typedef struct packed {
        logic [15:0] pkt_len;
        logic        good;
        logic        bad;
        logic        bad_fcs;
        logic        oversize;
        logic        framing;
        logic        ucast;
        logic        mcast;
        logic        bcast;
        logic        vlan;
    } rx_stat_t;

endpackage

`default_nettype wire

/* gmii_rx.f */
common/gmii_rx_pkg.sv
hdl/rx_delay_line.sv
hdl/rx_fcs_check.sv
rx_frame/rx_hdr_classify.sv
rx_frame/rx_frame_ctrl.sv
hdl/gmii_rx.sv
testbench/tb_gmii_rx.sv

/* hdl/gmii_rx.sv */
// gmii receive path, byte mode; MAX_PKT_LEN counts from the byte after sfd through the fcs
`timescale 1ns/1ps
`default_nettype none

module gmii_rx #(
    parameter int MAX_PKT_LEN = 1518
) (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire gmii_rx_pkg::gmii_sample_t gmii_in,
    output gmii_rx_pkg::rx_beat_t          rx_out,
    output gmii_rx_pkg::rx_stat_t          rx_stat
);

    gmii_rx_pkg::gmii_sample_t tap_head;
    gmii_rx_pkg::gmii_sample_t tap_tail;
    gmii_rx_pkg::hdr_flags_t   flags;

    logic fcs_ok;
    logic crc_clear;
    logic crc_update;
    logic hdr_clear;
    logic hdr_step;

    rx_delay_line rx_delay_line_inst (
        .clk       (clk),
        .reset_crc (reset_crc),
        .gmii_in   (gmii_in),
        .tap_head  (tap_head),
        .tap_tail  (tap_tail)
    );

    rx_fcs_check rx_fcs_check_inst (
        .clk        (clk),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .data       (tap_head.data),
        .fcs_ok     (fcs_ok)
    );

    rx_hdr_classify rx_hdr_classify_inst (
        .clk       (clk),
        .hdr_clear (hdr_clear),
        .hdr_step  (hdr_step),
        .data      (tap_tail.data),
        .flags     (flags)
    );

    rx_frame_ctrl #(
        .MAX_PKT_LEN (MAX_PKT_LEN)
    ) rx_frame_ctrl_inst (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .gmii_in    (gmii_in),
        .tap_head   (tap_head),
        .tap_tail   (tap_tail),
        .fcs_ok     (fcs_ok),
        .flags      (flags),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .hdr_clear  (hdr_clear),
        .hdr_step   (hdr_step),
        .rx_out     (rx_out),
        .rx_stat    (rx_stat)
    );

endmodule

`default_nettype wire

/* hdl/rx_delay_line.sv */
// five fixed stages; only dv and er are cleared by reset, data is don't-care until refilled
`timescale 1ns/1ps
`default_nettype none

module rx_delay_line (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire gmii_rx_pkg::gmii_sample_t gmii_in,
    output gmii_rx_pkg::gmii_sample_t      tap_head,
    output gmii_rx_pkg::gmii_sample_t      tap_tail
);

    localparam int DEPTH = 5;

    // stage 0 feeds the crc, the last stage is four bytes behind it
    gmii_rx_pkg::gmii_sample_t stage [0:DEPTH-1];

    always_ff @(posedge clk) begin
        stage[0] <= gmii_in;
        for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
        end

        if (reset_crc) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i].dv <= 1'b0;
                stage[i].er <= 1'b0;
            end
        end
    end

    assign tap_head = stage[0];
    assign tap_tail = stage[DEPTH-1];

endmodule

`default_nettype wire

/* hdl/rx_fcs_check.sv */
// one byte per update, lsb first; fcs_ok is only meaningful while the last fcs byte is on data
`timescale 1ns/1ps
`default_nettype none

module rx_fcs_check (
    input  wire logic                           clk,
    input  wire logic                           crc_clear,
    input  wire logic                           crc_update,
    input  wire logic [gmii_rx_pkg::BYTE_W-1:0] data,
    output logic                                fcs_ok
);

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // bitwise galois step over one byte
    always_comb begin
        crc_next = crc_reg;
        for (int i = 0; i < gmii_rx_pkg::BYTE_W; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ gmii_rx_pkg::CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crc_clear) begin
            crc_reg <= '1;
        end else if (crc_update) begin
            crc_reg <= crc_next;
        end
    end

    // frame plus its own fcs leaves the fixed residue
    assign fcs_ok = crc_next == gmii_rx_pkg::CRC_RESIDUE;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the gmii receive testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_gmii_rx -f gmii_rx.f -o sim_gmii_rx || exit 1
out=$(./obj_dir/sim_gmii_rx)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1

/* rx_frame/rx_frame_ctrl.sv */
// no back-pressure on rx_out; frame end is taken from undelayed dv, er counts only with dv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_ctrl #(
    parameter int MAX_PKT_LEN = 1518
) (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire gmii_rx_pkg::gmii_sample_t gmii_in,
    input  wire gmii_rx_pkg::gmii_sample_t tap_head,
    input  wire gmii_rx_pkg::gmii_sample_t tap_tail,
    input  wire logic                      fcs_ok,
    input  wire gmii_rx_pkg::hdr_flags_t   flags,
    output logic                           crc_clear,
    output logic                           crc_update,
    output logic                           hdr_clear,
    output logic                           hdr_step,
    output gmii_rx_pkg::rx_beat_t          rx_out,
    output gmii_rx_pkg::rx_stat_t          rx_stat
);

    gmii_rx_pkg::rx_state_t state_reg, state_next;

    logic        pre_seen_reg, pre_seen_next;
    logic        frame_err_reg, frame_err_next;
    logic [15:0] len_reg, len_next;
    logic        oversize;
    logic        good;

    gmii_rx_pkg::rx_beat_t out_next;
    gmii_rx_pkg::rx_stat_t stat_next;

    // crc runs from the byte after sfd, header from the first payload beat
    assign crc_clear  = state_reg == gmii_rx_pkg::STATE_IDLE;
    assign crc_update = !crc_clear;
    assign hdr_step   = state_reg == gmii_rx_pkg::STATE_PAYLOAD;
    assign hdr_clear  = !hdr_step;

    assign oversize = int'(len_reg) > MAX_PKT_LEN;
    assign good     = fcs_ok && !frame_err_reg && !oversize;

    always_comb begin
        state_next     = state_reg;
        pre_seen_next  = pre_seen_reg;
        frame_err_next = frame_err_reg;
        len_next       = len_reg;
        out_next       = '0;
        stat_next      = '0;

        if (len_reg != 16'hffff) begin
            len_next = len_reg + 16'd1;
        end

        if (gmii_in.dv && gmii_in.er) begin
            frame_err_next = 1'b1;
        end

        case (state_reg)
            gmii_rx_pkg::STATE_IDLE: begin
                len_next = 16'd1;
                // gmii_in already holds the first byte after a head sfd
                frame_err_next = gmii_in.dv && gmii_in.er;

                if (!tap_head.dv || tap_head.er) begin
                    pre_seen_next = 1'b0;
                end else if (tap_head.data == gmii_rx_pkg::ETH_PRE) begin
                    pre_seen_next = 1'b1;
                end else if (tap_head.data == gmii_rx_pkg::ETH_SFD) begin
                    pre_seen_next = 1'b0;
                    if (pre_seen_reg) begin
                        state_next = gmii_rx_pkg::STATE_PIPE;
                    end
                end else begin
                    pre_seen_next = 1'b0;
                end
            end
            gmii_rx_pkg::STATE_PIPE: begin
                // wait for sfd to reach the tail
                if (tap_tail.dv && !tap_tail.er && tap_tail.data == gmii_rx_pkg::ETH_SFD) begin
                    state_next = gmii_rx_pkg::STATE_PAYLOAD;
                end
            end
            gmii_rx_pkg::STATE_PAYLOAD: begin
                out_next.data  = tap_tail.data;
                out_next.valid = 1'b1;

                if (!gmii_in.dv) begin
                    // fcs now sits in stages 0 to 3
                    out_next.last      = 1'b1;
                    out_next.user      = !good;
                    stat_next.pkt_len  = len_reg;
                    stat_next.good     = good;
                    stat_next.bad      = frame_err_reg || !fcs_ok || oversize;
                    stat_next.bad_fcs  = !fcs_ok && !frame_err_reg;
                    stat_next.oversize = oversize;
                    stat_next.framing  = frame_err_reg;
                    stat_next.ucast    = !flags.mcast;
                    stat_next.mcast    = flags.mcast && !flags.bcast;
                    stat_next.bcast    = flags.bcast;
                    stat_next.vlan     = flags.vlan;
                    state_next         = gmii_rx_pkg::STATE_IDLE;
                end
            end
            default: begin
                state_next = gmii_rx_pkg::STATE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state_reg     <= state_next;
        pre_seen_reg  <= pre_seen_next;
        frame_err_reg <= frame_err_next;
        len_reg       <= len_next;
        rx_out        <= out_next;
        rx_stat       <= stat_next;

        if (reset_crc) begin
            state_reg     <= gmii_rx_pkg::STATE_IDLE;
            pre_seen_reg  <= 1'b0;
            frame_err_reg <= 1'b0;
            len_reg       <= '0;
            rx_out.valid  <= 1'b0;
            rx_out.last   <= 1'b0;
            rx_stat       <= '0;
        end
    end

    // last beat and status pulse share one cycle
    a_last_valid: assert property (@(posedge clk) disable iff (reset_crc)
        rx_out.last |-> rx_out.valid && rx_stat.pkt_len != 16'd0);

    a_good_bad_excl: assert property (@(posedge clk) disable iff (reset_crc)
        (rx_stat.good || rx_stat.bad) |->
            !(rx_stat.good && rx_stat.bad) && rx_stat.pkt_len != 16'd0);

endmodule

`default_nettype wire

/* rx_frame/rx_hdr_classify.sv */
// flags hold until hdr_clear; frames shorter than 14 payload bytes leave them partly built
`timescale 1ns/1ps
`default_nettype none

module rx_hdr_classify (
    input  wire logic                           clk,
    input  wire logic                           hdr_clear,
    input  wire logic                           hdr_step,
    input  wire logic [gmii_rx_pkg::BYTE_W-1:0] data,
    output gmii_rx_pkg::hdr_flags_t             flags
);

    // saturates at 15, past the ethertype
    logic [3:0] ptr_reg;

    always_ff @(posedge clk) begin
        if (hdr_clear) begin
            ptr_reg <= '0;
            flags   <= '0;
        end else if (hdr_step) begin
            if (ptr_reg != 4'hf) begin
                ptr_reg <= ptr_reg + 4'd1;
            end

            case (ptr_reg)
                4'd0: begin
                    flags.mcast <= data[0];
                    flags.bcast <= data == 8'hff;
                end
                4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                    flags.bcast <= flags.bcast && data == 8'hff;
                end
                // 802.1q tpid
                4'd12: flags.vlan <= data == 8'h81;
                4'd13: flags.vlan <= flags.vlan && data == 8'h00;
                default: begin
                end
            endcase
        end
    end

    // frame controller never steps while clearing
    a_clear_step_excl: assert property (@(posedge clk) hdr_step |-> !hdr_clear);

endmodule

`default_nettype wire

/* testbench/tb_gmii_rx.sv */
// runs with MAX_PKT_LEN at 100; frames are 7 preamble bytes, sfd, body, fcs, then 12 idle cycles
`timescale 1ns/1ps
`default_nettype none

module tb_gmii_rx;

    localparam int MAX_LEN = 100;
    // six frames of up to 140 cycles each, plus reset and margin
    localparam int TIMEOUT_CYCLES = 2000;

    typedef logic [7:0] byte_q_t [$];

    logic                      clk;
    logic                      reset_crc;
    gmii_rx_pkg::gmii_sample_t gmii_in;
    gmii_rx_pkg::rx_beat_t     rx_out;
    gmii_rx_pkg::rx_stat_t     rx_stat;

    byte_q_t               exp_bytes;
    gmii_rx_pkg::rx_stat_t exp_stat;
    logic [31:0]           lcg_state;
    int                    errors;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    stat_cnt;
    int                    cycle_cnt;

    gmii_rx #(
        .MAX_PKT_LEN (MAX_LEN)
    ) gmii_rx_inst (
        .clk       (clk),
        .reset_crc (reset_crc),
        .gmii_in   (gmii_in),
        .rx_out    (rx_out),
        .rx_stat   (rx_stat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ethernet crc-32, reflected, inverted at the end
    function automatic logic [31:0] crc32(input byte_q_t bytes);
        logic [31:0] crc;
        crc = 32'hffffffff;
        foreach (bytes[n]) begin
            for (int i = 0; i < 8; i++) begin
                if (crc[0] ^ bytes[n][i]) begin
                    crc = (crc >> 1) ^ 32'hedb88320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    // expected status from the frame bytes as sent, fcs included
    function automatic gmii_rx_pkg::rx_stat_t ref_stat(input byte_q_t f, input logic er_seen);
        gmii_rx_pkg::rx_stat_t s;
        byte_q_t               body;
        logic [31:0]           fcs_rx;
        logic                  fcs_match;
        logic                  all_ff;
        int                    n;
        n = f.size();
        for (int i = 0; i < n - 4; i++) begin
            body.push_back(f[i]);
        end
        fcs_rx    = {f[n-1], f[n-2], f[n-3], f[n-4]};
        fcs_match = fcs_rx == crc32(body);
        all_ff    = {f[0], f[1], f[2], f[3], f[4], f[5]} == 48'hffffffffffff;
        s          = '0;
        s.pkt_len  = 16'(n);
        s.oversize = n > MAX_LEN;
        s.framing  = er_seen;
        s.bad_fcs  = !fcs_match && !er_seen;
        s.good     = fcs_match && !er_seen && !s.oversize;
        s.bad      = !s.good;
        s.bcast    = all_ff;
        s.mcast    = f[0][0] && !all_ff;
        s.ucast    = !s.bcast && !s.mcast;
        s.vlan     = f[12] == 8'h81 && f[13] == 8'h00;
        return s;
    endfunction

    task automatic check_beat(input gmii_rx_pkg::rx_beat_t got, input gmii_rx_pkg::rx_beat_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t rx_out got=%h exp=%h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_stat(input gmii_rx_pkg::rx_stat_t got, input gmii_rx_pkg::rx_stat_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t rx_stat got=%h exp=%h", $time, got, exp);
            errors++;
        end
    endtask

    // dst, src, ethertype or tpid, random fill, then fcs lsb first
    task automatic build_frame(input logic [47:0] dst, input int len, input logic vlan,
                               output byte_q_t f);
        logic [31:0] fcs;
        f.delete();
        for (int i = 5; i >= 0; i--) begin
            f.push_back(dst[8*i +: 8]);
        end
        while (f.size() < len - 4) begin
            lcg_state = lcg_step(lcg_state);
            f.push_back(lcg_state[23:16]);
        end
        f[12] = vlan ? 8'h81 : 8'h08;
        f[13] = 8'h00;
        fcs = crc32(f);
        for (int k = 0; k < 4; k++) begin
            f.push_back(fcs[8*k +: 8]);
        end
    endtask

    task automatic drive_byte(input logic [7:0] data, input logic er);
        @(posedge clk);
        #1;
        gmii_in.data = data;
        gmii_in.dv   = 1'b1;
        gmii_in.er   = er;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_before);
            fail_cnt++;
        end
    endtask

    // er_idx below zero sends the frame without er
    task automatic run_frame(input string name, input byte_q_t f, input int er_idx);
        int err_before;
        int start_cnt;
        err_before = errors;
        start_cnt  = stat_cnt;
        exp_stat   = ref_stat(f, er_idx >= 0 && er_idx < f.size());
        exp_bytes.delete();
        for (int i = 0; i < f.size() - 4; i++) begin
            exp_bytes.push_back(f[i]);
        end
        for (int i = 0; i < 7; i++) begin
            drive_byte(8'h55, 1'b0);
        end
        drive_byte(8'hd5, 1'b0);
        foreach (f[i]) begin
            drive_byte(f[i], i == er_idx);
        end
        @(posedge clk);
        #1;
        gmii_in = '0;
        while (stat_cnt == start_cnt) begin
            @(posedge clk);
        end
        repeat (12) @(posedge clk);
        report_test(name, err_before);
    endtask

    always @(negedge clk) begin : monitor
        gmii_rx_pkg::rx_beat_t exp_beat;
        if (!reset_crc && rx_out.valid) begin
            if (exp_bytes.size() == 0) begin
                $display("unexpected beat on rx_out at time %0t", $time);
                errors++;
            end else begin
                exp_beat.data  = exp_bytes.pop_front();
                exp_beat.valid = 1'b1;
                exp_beat.last  = exp_bytes.size() == 0;
                exp_beat.user  = exp_beat.last && exp_stat.bad;
                check_beat(rx_out, exp_beat);
            end
        end
        if (!reset_crc && rx_stat.pkt_len != 16'd0) begin
            if (!(rx_out.valid && rx_out.last)) begin
                $display("rx_stat pulsed at time %0t without the last beat of a frame", $time);
                errors++;
            end
            check_stat(rx_stat, exp_stat);
            if (exp_bytes.size() != 0) begin
                $display("frame ended with %0d bytes never received", exp_bytes.size());
                errors++;
            end
            exp_bytes.delete();
            stat_cnt++;
        end else if (!reset_crc && rx_stat != '0) begin
            $display("rx_stat flags set at time %0t outside the end-of-frame pulse", $time);
            errors++;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        byte_q_t good_frame;
        byte_q_t frame;
        int      err_before;
        gmii_in   = '0;
        reset_crc = 1'b1;
        lcg_state = 32'h9a28_3896;
        errors    = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        stat_cnt  = 0;
        repeat (2) @(posedge clk);
        #1;
        reset_crc = 1'b0;

        // quiet outputs before any frame
        err_before = errors;
        repeat (10) begin
            @(negedge clk);
            check_beat(rx_out, '0);
            check_stat(rx_stat, '0);
        end
        report_test("after_reset", err_before);

        build_frame(48'h02_11_22_33_44_55, 64, 1'b0, good_frame);
        run_frame("good_unicast", good_frame, -1);

        frame = good_frame;
        frame[frame.size()-1] = frame[frame.size()-1] ^ 8'h10;
        run_frame("bad_fcs", frame, -1);

        run_frame("er_mid_frame", good_frame, 30);

        build_frame(48'h02_11_22_33_44_55, 120, 1'b0, frame);
        run_frame("oversize", frame, -1);

        build_frame(48'hff_ff_ff_ff_ff_ff, 64, 1'b1, frame);
        run_frame("bcast_vlan", frame, -1);

        build_frame(48'h01_00_5e_00_00_01, 64, 1'b0, frame);
        run_frame("mcast", frame, -1);

        $display("tests passed %0d failed %0d, total errors %0d", pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
